// ==== hw/core_pkg.sv ====
package core_pkg;

    ////////////////////
    // sizes
    ////////////////////

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_AW    = 6;

    ////////////////////
    // opcodes
    ////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // alu operation codes
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
    // lui result is the immediate itself
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    // writeback source
    localparam logic WB_ALU  = 1'b0;
    localparam logic WB_LOAD = 1'b1;

    ////////////////////
    // instruction word
    ////////////////////

    // one word, four field layouts picked by opcode
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r;
        struct packed {
            logic [11:0]       imm12;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i;
        struct packed {
            logic [6:0]        imm_hi;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [4:0]        imm_lo;
            logic [6:0]        opcode;
        } s;
        // branch offset is scattered, bit 0 implied zero
        struct packed {
            logic              imm12;
            logic [5:0]        imm10_5;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [3:0]        imm4_1;
            logic              imm11;
            logic [6:0]        opcode;
        } b;
    } instr_u;

    ////////////////////
    // stage registers
    ////////////////////

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        logic [XLEN-1:0]     pc;
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [XLEN-1:0]     rs1_data;
        logic [XLEN-1:0]     rs2_data;
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     imm;
        logic [ALU_OP_W-1:0] alu_op;
        logic                use_imm;
        logic                is_branch;
        logic [2:0]          br_funct3;
        logic                mem_read;
        logic                mem_write;
        logic                reg_write;
        logic                wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   store_data;
        logic              mem_read;
        logic              mem_write;
        logic              reg_write;
        logic              wb_sel;
    } ex_mem_t;

    // register write, also forwarded and reported as retire
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [core_pkg::REG_AW-1:0] i_rs1_addr,
    input  logic [core_pkg::REG_AW-1:0] i_rs2_addr,
    input  core_pkg::wb_t               i_wb,
    output logic [core_pkg::XLEN-1:0]   o_rs1_data,
    output logic [core_pkg::XLEN-1:0]   o_rs2_data
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:(1 << core_pkg::REG_AW) - 1];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < (1 << core_pkg::REG_AW); i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb.valid && (i_wb.rd != '0))
        begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // x0 reads zero, same-cycle write passes straight through
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                        (i_wb.valid && (i_wb.rd == i_rs1_addr)) ? i_wb.data :
                        regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                        (i_wb.valid && (i_wb.rd == i_rs2_addr)) ? i_wb.data :
                        regs[i_rs2_addr];

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_imem_we,
    input  logic [core_pkg::IMEM_AW-1:0] i_imem_addr,
    input  logic [core_pkg::XLEN-1:0]    i_imem_data,
    input  logic                         i_stall,
    input  core_pkg::redirect_t          i_redirect,
    output core_pkg::if_id_t             o_if_id
);

    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] imem [core_pkg::IMEM_WORDS];
    logic [core_pkg::XLEN-1:0] instr;
    core_pkg::if_id_t          if_id_q;

    // program load port, used while core is held in reset
    always_ff @(posedge clk)
    begin
        if (i_imem_we)
        begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // async read at pc word index
    assign instr = imem[pc[core_pkg::IMEM_AW+1:2]];

    ////////////////////
    // program counter
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc <= '0;
        end
        // taken branch beats a load-use hold
        else if (i_redirect.valid)
        begin
            pc <= i_redirect.target;
        end
        else if (!i_stall)
        begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            if_id_q.valid <= 1'b0;
        end
        else if (i_redirect.valid)
        begin
            // wrong-path fetch dropped
            if_id_q.valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc;
            if_id_q.instr <= instr;
        end
    end

    assign o_if_id = if_id_q;

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::if_id_t    i_if_id,
    input  core_pkg::redirect_t i_redirect,
    input  core_pkg::wb_t       i_wb,
    output logic                o_stall,
    output core_pkg::id_ex_t    o_id_ex
);

    core_pkg::instr_u          instr;
    core_pkg::id_ex_t          dec;
    core_pkg::id_ex_t          id_ex_q;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;
    logic                      writes_rd;
    logic                      uses_rs1;
    logic                      uses_rs2;

    // funct3 to alu code, alt picks sub or sra
    function automatic logic [core_pkg::ALU_OP_W-1:0] alu_decode(
        input logic [2:0] funct3,
        input logic       alt
    );
        case (funct3)
            3'b000:  alu_decode = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  alu_decode = core_pkg::ALU_SLL;
            3'b010:  alu_decode = core_pkg::ALU_SLT;
            3'b011:  alu_decode = core_pkg::ALU_SLTU;
            3'b100:  alu_decode = core_pkg::ALU_XOR;
            3'b101:  alu_decode = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  alu_decode = core_pkg::ALU_OR;
            default: alu_decode = core_pkg::ALU_AND;
        endcase
    endfunction

    assign instr = i_if_id.instr;

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1_addr (instr.r.rs1),
        .i_rs2_addr (instr.r.rs2),
        .i_wb       (i_wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    ////////////////////
    // decode
    ////////////////////

    always_comb
    begin
        dec       = '0;
        writes_rd = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        // fields at fixed positions in every layout
        dec.valid    = i_if_id.valid;
        dec.pc       = i_if_id.pc;
        dec.rs1      = instr.r.rs1;
        dec.rs2      = instr.r.rs2;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rd       = instr.r.rd;
        dec.alu_op   = core_pkg::ALU_ADD;
        dec.wb_sel   = core_pkg::WB_ALU;
        case (instr.r.opcode)
            core_pkg::OPC_OP:
            begin
                dec.alu_op = alu_decode(instr.r.funct3, instr.r.funct7[5]);
                writes_rd  = 1'b1;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
            end
            core_pkg::OPC_OP_IMM:
            begin
                // imm bit 30 only means sra on the shift-right form
                dec.alu_op  = alu_decode(instr.i.funct3,
                                         (instr.i.funct3 == 3'b101) && instr.r.funct7[5]);
                dec.imm     = {{(core_pkg::XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                dec.use_imm = 1'b1;
                writes_rd   = 1'b1;
                uses_rs1    = 1'b1;
            end
            core_pkg::OPC_LUI:
            begin
                // upper 20 bits sit where imm12, rs1, funct3 are
                dec.imm     = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};
                dec.alu_op  = core_pkg::ALU_PASS_B;
                dec.use_imm = 1'b1;
                writes_rd   = 1'b1;
            end
            core_pkg::OPC_LOAD:
            begin
                dec.imm      = {{(core_pkg::XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                dec.use_imm  = 1'b1;
                dec.mem_read = 1'b1;
                dec.wb_sel   = core_pkg::WB_LOAD;
                writes_rd    = 1'b1;
                uses_rs1     = 1'b1;
            end
            core_pkg::OPC_STORE:
            begin
                dec.imm       = {{(core_pkg::XLEN-12){instr.s.imm_hi[6]}},
                                 instr.s.imm_hi, instr.s.imm_lo};
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
            end
            core_pkg::OPC_BRANCH:
            begin
                dec.imm       = {{(core_pkg::XLEN-13){instr.b.imm12}}, instr.b.imm12,
                                 instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                dec.is_branch = 1'b1;
                dec.br_funct3 = instr.b.funct3;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
            end
            // anything else passes as a no-op
            default: ;
        endcase
        // writes to x0 are dropped here
        dec.reg_write = writes_rd && (instr.r.rd != '0);
    end

    ////////////////////
    // load-use hazard
    ////////////////////

    // load one stage ahead, its data only exists after mem
    assign o_stall = i_if_id.valid && id_ex_q.valid && id_ex_q.mem_read &&
                     (id_ex_q.rd != '0) &&
                     ((uses_rs1 && (id_ex_q.rd == instr.r.rs1)) ||
                      (uses_rs2 && (id_ex_q.rd == instr.r.rs2)));

    // ID/EX register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            id_ex_q.valid <= 1'b0;
        end
        else
        begin
            id_ex_q <= dec;
            // bubble on stall, flush on taken branch
            if (i_redirect.valid || o_stall)
            begin
                id_ex_q.valid <= 1'b0;
            end
        end
    end

    assign o_id_ex = id_ex_q;

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::id_ex_t    i_id_ex,
    input  core_pkg::wb_t       i_wb,
    output core_pkg::redirect_t o_redirect,
    output core_pkg::ex_mem_t   o_ex_mem
);

    core_pkg::ex_mem_t         ex_mem_q;
    logic [core_pkg::XLEN-1:0] rs1_val;
    logic [core_pkg::XLEN-1:0] rs2_val;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_result;
    logic                      br_cond;

    // newest producer first, ex/mem then writeback then id/ex copy
    function automatic logic [core_pkg::XLEN-1:0] forward(
        input logic [core_pkg::REG_AW-1:0] idx,
        input logic [core_pkg::XLEN-1:0]   reg_val,
        input core_pkg::ex_mem_t           ex_mem,
        input core_pkg::wb_t               wb
    );
        // a load in ex/mem has no data yet
        if ((idx != '0) && ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
            (ex_mem.rd == idx))
            forward = ex_mem.alu_result;
        else if ((idx != '0) && wb.valid && (wb.rd == idx))
            forward = wb.data;
        else
            forward = reg_val;
    endfunction

    ////////////////////
    // operands and alu
    ////////////////////

    assign rs1_val = forward(i_id_ex.rs1, i_id_ex.rs1_data, ex_mem_q, i_wb);
    assign rs2_val = forward(i_id_ex.rs2, i_id_ex.rs2_data, ex_mem_q, i_wb);
    assign op_b    = i_id_ex.use_imm ? i_id_ex.imm : rs2_val;

    // loads and stores use add for rs1 plus imm
    always_comb
    begin
        case (i_id_ex.alu_op)
            core_pkg::ALU_ADD:    alu_result = rs1_val + op_b;
            core_pkg::ALU_SUB:    alu_result = rs1_val - op_b;
            core_pkg::ALU_AND:    alu_result = rs1_val & op_b;
            core_pkg::ALU_OR:     alu_result = rs1_val | op_b;
            core_pkg::ALU_XOR:    alu_result = rs1_val ^ op_b;
            core_pkg::ALU_SLT:
                alu_result = {{(core_pkg::XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            core_pkg::ALU_SLTU:
                alu_result = {{(core_pkg::XLEN-1){1'b0}}, rs1_val < op_b};
            // shift amount is the low five bits
            core_pkg::ALU_SLL:    alu_result = rs1_val << op_b[4:0];
            core_pkg::ALU_SRL:    alu_result = rs1_val >> op_b[4:0];
            core_pkg::ALU_SRA:    alu_result = $signed(rs1_val) >>> op_b[4:0];
            core_pkg::ALU_PASS_B: alu_result = op_b;
            default:              alu_result = '0;
        endcase
    end

    ////////////////////
    // branch resolve
    ////////////////////

    always_comb
    begin
        case (i_id_ex.br_funct3)
            3'b000:  br_cond = (rs1_val == rs2_val);
            3'b001:  br_cond = (rs1_val != rs2_val);
            3'b100:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  br_cond = (rs1_val < rs2_val);
            3'b111:  br_cond = (rs1_val >= rs2_val);
            default: br_cond = 1'b0;
        endcase
    end

    // predict not taken, so only a taken branch redirects
    assign o_redirect.valid  = i_id_ex.valid && i_id_ex.is_branch && br_cond;
    assign o_redirect.target = i_id_ex.pc + i_id_ex.imm;

    // EX/MEM register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex_mem_q.valid <= 1'b0;
        end
        else
        begin
            ex_mem_q.valid      <= i_id_ex.valid;
            ex_mem_q.rd         <= i_id_ex.rd;
            ex_mem_q.alu_result <= alu_result;
            ex_mem_q.store_data <= rs2_val;
            ex_mem_q.mem_read   <= i_id_ex.mem_read;
            ex_mem_q.mem_write  <= i_id_ex.mem_write;
            ex_mem_q.reg_write  <= i_id_ex.reg_write;
            ex_mem_q.wb_sel     <= i_id_ex.wb_sel;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::ex_mem_t i_ex_mem,
    output core_pkg::wb_t     o_wb
);

    logic [core_pkg::XLEN-1:0]    dmem [core_pkg::DMEM_WORDS];
    logic [core_pkg::DMEM_AW-1:0] word_idx;
    logic [core_pkg::XLEN-1:0]    load_data;
    core_pkg::wb_t                wb_d;
    core_pkg::wb_t                wb_q;

    // word access only, byte offset ignored
    assign word_idx  = i_ex_mem.alu_result[core_pkg::DMEM_AW+1:2];
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk)
    begin
        if (i_ex_mem.valid && i_ex_mem.mem_write)
        begin
            dmem[word_idx] <= i_ex_mem.store_data;
        end
    end

    ////////////////////
    // writeback select
    ////////////////////

    always_comb
    begin
        wb_d.valid = i_ex_mem.valid && i_ex_mem.reg_write;
        wb_d.rd    = i_ex_mem.rd;
        wb_d.data  = (i_ex_mem.wb_sel == core_pkg::WB_LOAD) ? load_data : i_ex_mem.alu_result;
    end

    // MEM/WB register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_q.valid <= 1'b0;
        end
        else
        begin
            wb_q <= wb_d;
        end
    end

    assign o_wb = wb_q;

endmodule

// ==== hw/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_imem_we,
    input  logic [core_pkg::IMEM_AW-1:0] i_imem_addr,
    input  logic [core_pkg::XLEN-1:0]    i_imem_data,
    output core_pkg::wb_t                o_retire
);

    core_pkg::if_id_t    if_id;
    core_pkg::id_ex_t    id_ex;
    core_pkg::ex_mem_t   ex_mem;
    core_pkg::wb_t       wb;
    core_pkg::redirect_t redirect;
    logic                stall;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .o_if_id     (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_if_id    (if_id),
        .i_redirect (redirect),
        .i_wb       (wb),
        .o_stall    (stall),
        .o_id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_id_ex    (id_ex),
        .i_wb       (wb),
        .o_redirect (redirect),
        .o_ex_mem   (ex_mem)
    );

    memory_stage u_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_ex_mem (ex_mem),
        .o_wb     (wb)
    );

    // each register write is one retire
    assign o_retire = wb;

endmodule

// ==== bench/core_assert.sv ====
`timescale 1ns/1ps

module core_assert (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::wb_t       i_retire,
    input  core_pkg::redirect_t i_redirect,
    input  logic                i_stall,
    input  core_pkg::if_id_t    i_if_id,
    input  core_pkg::id_ex_t    i_id_ex
);

    int fail_count = 0;

    ////////////////////
    // retire port
    ////////////////////

    // first reset edge may still see power-up state
    a_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !i_retire.valid)
        else
        begin
            fail_count = fail_count + 1;
            $error("retire valid during reset");
        end

    a_no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
        i_retire.valid |-> (i_retire.rd != '0))
        else
        begin
            fail_count = fail_count + 1;
            $error("retire reported for x0");
        end

    ////////////////////
    // pipeline control
    ////////////////////

    // redirect flushes both younger stages even during a stall
    a_flush_if_id: assert property (@(posedge clk) disable iff (!rst_n)
        i_redirect.valid |=> !i_if_id.valid)
        else
        begin
            fail_count = fail_count + 1;
            $error("IF/ID valid after redirect");
        end

    a_flush_id_ex: assert property (@(posedge clk) disable iff (!rst_n)
        i_redirect.valid |=> !i_id_ex.valid)
        else
        begin
            fail_count = fail_count + 1;
            $error("ID/EX valid after redirect");
        end

    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (i_stall && !i_redirect.valid) |=> $stable(i_if_id))
        else
        begin
            fail_count = fail_count + 1;
            $error("IF/ID moved during stall");
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        i_if_id.valid |-> (i_if_id.pc[1:0] == 2'b00))
        else
        begin
            fail_count = fail_count + 1;
            $error("fetched pc not word aligned");
        end

endmodule

bind riscv_core core_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_retire   (o_retire),
    .i_redirect (redirect),
    .i_stall    (stall),
    .i_if_id    (if_id),
    .i_id_ex    (id_ex)
);

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 16;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         imem_we;
    logic [core_pkg::IMEM_AW-1:0] imem_addr;
    logic [core_pkg::XLEN-1:0]    imem_data;
    core_pkg::wb_t                retire;

    // program table with one entry per instruction word
    string       names [$];
    logic [31:0] words [$];
    logic [4:0]  rds   [$];
    logic [31:0] vals  [$];
    // rows that must retire in program order
    int          exp_idx [$];

    int errors  = 0;
    int checked = 0;
    int seed    = 85;

    riscv_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_retire    (retire)
    );

    always #2 clk = ~clk;

    ////////////////////
    // instruction words
    ////////////////////

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
    endfunction

    // shifts carry funct7 in imm[11:5]
    function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, core_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, core_pkg::OPC_LOAD};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OPC_STORE};
    endfunction

    // offset bit 0 is implied zero
    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::OPC_BRANCH};
    endfunction

    ////////////////////
    // table building
    ////////////////////

    task automatic add_row(input string name, input logic [31:0] word, input bit ret,
                           input logic [4:0] rd, input logic [31:0] value);
        if (ret)
            exp_idx.push_back(words.size());
        names.push_back(name);
        words.push_back(word);
        rds.push_back(rd);
        vals.push_back(value);
    endtask

    // taken branch skips two rows and lands on a not-taken one
    // fall row only retires if both resolved right
    task automatic branch_pair(input string name, input logic [2:0] f3,
                               input logic [4:0] t_rs1, input logic [4:0] t_rs2,
                               input logic [4:0] n_rs1, input logic [4:0] n_rs2,
                               input logic [11:0] mark);
        add_row({name, " taken"}, branch_word(f3, t_rs1, t_rs2, 13'd12), 0, 0, 0);
        add_row({name, " skip1"}, imm_op(3'b000, 6, 0, 12'hFFF), 0, 0, 0);
        add_row({name, " skip2"}, imm_op(3'b000, 6, 0, 12'hFFE), 0, 0, 0);
        add_row({name, " not taken"}, branch_word(f3, n_rs1, n_rs2, 13'd8), 0, 0, 0);
        add_row({name, " fall"}, imm_op(3'b000, 6, 0, mark), 1, 6, {20'd0, mark});
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [31:0] sum;
        // alu ops on x1 = 5 and x2 = -3
        add_row("addi", imm_op(3'b000, 1, 0, 12'd5), 1, 1, 32'h0000_0005);
        add_row("addi neg", imm_op(3'b000, 2, 0, 12'hFFD), 1, 2, 32'hFFFF_FFFD);
        add_row("add", reg_op(7'h00, 3'b000, 3, 1, 2), 1, 3, 32'h0000_0002);
        add_row("sub", reg_op(7'h20, 3'b000, 4, 1, 2), 1, 4, 32'h0000_0008);
        add_row("and", reg_op(7'h00, 3'b111, 5, 1, 2), 1, 5, 32'h0000_0005);
        add_row("or", reg_op(7'h00, 3'b110, 6, 1, 2), 1, 6, 32'hFFFF_FFFD);
        add_row("xor", reg_op(7'h00, 3'b100, 7, 1, 2), 1, 7, 32'hFFFF_FFF8);
        add_row("slt", reg_op(7'h00, 3'b010, 8, 2, 1), 1, 8, 32'h0000_0001);
        add_row("sltu", reg_op(7'h00, 3'b011, 9, 2, 1), 1, 9, 32'h0000_0000);
        add_row("sll", reg_op(7'h00, 3'b001, 10, 1, 1), 1, 10, 32'h0000_00A0);
        add_row("srl", reg_op(7'h00, 3'b101, 11, 2, 1), 1, 11, 32'h07FF_FFFF);
        add_row("sra", reg_op(7'h20, 3'b101, 12, 2, 1), 1, 12, 32'hFFFF_FFFF);
        add_row("lui", lui_word(13, 20'h12345), 1, 13, 32'h1234_5000);
        add_row("ori", imm_op(3'b110, 14, 13, 12'h678), 1, 14, 32'h1234_5678);
        add_row("xori", imm_op(3'b100, 15, 14, 12'hFFF), 1, 15, 32'hEDCB_A987);
        add_row("andi", imm_op(3'b111, 16, 15, 12'h0F0), 1, 16, 32'h0000_0080);
        add_row("slti", imm_op(3'b010, 17, 2, 12'hFFE), 1, 17, 32'h0000_0001);
        add_row("sltiu", imm_op(3'b011, 18, 1, 12'hFFF), 1, 18, 32'h0000_0001);
        add_row("slli", imm_op(3'b001, 19, 1, 12'h01C), 1, 19, 32'h5000_0000);
        add_row("srli", imm_op(3'b101, 20, 15, 12'h004), 1, 20, 32'h0EDC_BA98);
        add_row("srai", imm_op(3'b101, 21, 15, 12'h404), 1, 21, 32'hFEDC_BA98);
        // dependent chain where the last row sees x22 in both ex/mem and wb
        add_row("chain 1", imm_op(3'b000, 22, 0, 12'd1), 1, 22, 32'd1);
        add_row("chain 2", reg_op(7'h00, 3'b000, 22, 22, 22), 1, 22, 32'd2);
        add_row("chain 3", reg_op(7'h00, 3'b000, 23, 22, 22), 1, 23, 32'd4);
        // store then load with a dependent add that stalls one cycle
        add_row("base", imm_op(3'b000, 26, 0, 12'h040), 1, 26, 32'h0000_0040);
        add_row("sw", sw_word(14, 26, 12'd8), 0, 0, 0);
        add_row("lw", lw_word(27, 26, 12'd8), 1, 27, 32'h1234_5678);
        add_row("load use", reg_op(7'h00, 3'b000, 28, 27, 27), 1, 28, 32'h2468_ACF0);
        // x0 stays zero
        add_row("addi x0", imm_op(3'b000, 0, 0, 12'd7), 0, 0, 0);
        add_row("read x0", reg_op(7'h00, 3'b000, 31, 0, 1), 1, 31, 32'h0000_0005);
        // random addi chain into x24
        sum = '0;
        for (int k = 0; k < 3; k++)
        begin
            rnd = $random(seed);
            imm = rnd[11:0];
            sum = sum + {{20{imm[11]}}, imm};
            add_row($sformatf("random addi %0d", k),
                    imm_op(3'b000, 24, (k == 0) ? 5'd0 : 5'd24, imm), 1, 24, sum);
        end
        // branch operands x1 = 5, x2 = -3 and x5 = 5
        branch_pair("beq", 3'b000, 1, 5, 1, 2, 12'd1);
        branch_pair("bne", 3'b001, 1, 2, 1, 5, 12'd2);
        branch_pair("blt", 3'b100, 2, 1, 1, 2, 12'd3);
        branch_pair("bge", 3'b101, 1, 2, 2, 1, 12'd4);
        branch_pair("bltu", 3'b110, 1, 2, 2, 1, 12'd5);
        branch_pair("bgeu", 3'b111, 2, 1, 1, 2, 12'd6);
        // park here forever
        add_row("self loop", branch_word(3'b000, 0, 0, 13'd0), 0, 0, 0);
    endtask

    ////////////////////
    // load and check
    ////////////////////

    task automatic load_program();
        for (int i = 0; i < words.size(); i++)
        begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i[core_pkg::IMEM_AW-1:0];
            imem_data <= words[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    // sampled on the falling edge away from the register updates
    task automatic check_retires();
        int r;
        for (int n = 0; n < exp_idx.size(); n++)
        begin
            do
                @(negedge clk);
            while (!retire.valid);
            r = exp_idx[n];
            if (retire.rd !== rds[r] || retire.data !== vals[r])
            begin
                errors++;
                $display("Error %s: expected x%0d = 0x%08h, actual x%0d = 0x%08h",
                         names[r], rds[r], vals[r], retire.rd, retire.data);
            end
            checked++;
        end
        // nothing more may retire once the core parks
        repeat (DRAIN_CYCLES)
        begin
            @(negedge clk);
            if (retire.valid)
            begin
                errors++;
                $display("unexpected retire of x%0d = 0x%08h after the last expected one",
                         retire.rd, retire.data);
            end
        end
    endtask

    initial
    begin
        rst_n     = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_program();
        if (words.size() > core_pkg::IMEM_WORDS)
        begin
            errors++;
            $display("program of %0d words does not fit the instruction memory", words.size());
        end
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        check_retires();
        $display("retires checked: %0d, errors: %0d, assertion failures: %0d",
                 checked, errors, dut.u_assert.fail_count);
        if (errors == 0 && dut.u_assert.fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // limit scales with program length
    initial
    begin : watchdog
        int limit;
        wait (rst_n === 1'b1);
        limit = words.size() * 4 + 40;
        repeat (limit) @(posedge clk);
        $display("timeout: only %0d of %0d expected retires arrived", checked, exp_idx.size());
        $display("test failed");
        $finish;
    end

endmodule

// ==== build.f ====
hw/core_pkg.sv
hw/regfile.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/riscv_core.sv
bench/core_assert.sv
bench/core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= core_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_ARGS   ?= +verilator+error+limit+100
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
